//--- logic/irq_pkg.sv
`default_nettype none

package irq_pkg;

  // one peripheral bus access. a zero wstrb is a read.
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    arb_idle,
    arb_issue,
    arb_wait
  } arb_state_e;

  typedef enum logic [1:0] {
    tgt_none,
    tgt_clint,
    tgt_clic
  } target_e;

  // regions are picked by addr[31:24].
  localparam logic [31:0] clint_base = 32'h0200_0000;
  localparam logic [31:0] clic_base  = 32'h0300_0000;

  localparam logic [15:0] clint_msip        = 16'h0000;
  localparam logic [15:0] clint_mtimecmp_lo = 16'h4000;
  localparam logic [15:0] clint_mtimecmp_hi = 16'h4004;
  localparam logic [15:0] clint_mtime_lo    = 16'hbff8;
  localparam logic [15:0] clint_mtime_hi    = 16'hbffc;

  localparam logic [15:0] clic_cfg      = 16'h0000;
  localparam logic [15:0] clic_info     = 16'h0004;
  localparam logic [15:0] clic_int_base = 16'h1000;

endpackage

`default_nettype wire

//--- logic/bus_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module bus_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  irq_pkg::bus_req_t core_req,
  input  irq_pkg::bus_req_t dbg_req,
  output irq_pkg::bus_rsp_t core_rsp,
  output irq_pkg::bus_rsp_t dbg_rsp,
  output irq_pkg::bus_req_t clint_req,
  output irq_pkg::bus_req_t clic_req,
  input  irq_pkg::bus_rsp_t clint_rsp,
  input  irq_pkg::bus_rsp_t clic_rsp
);

  irq_pkg::arb_state_e state;
  irq_pkg::target_e    tgt_q;
  irq_pkg::bus_req_t   req_q;
  irq_pkg::bus_req_t   pick_req;
  irq_pkg::bus_rsp_t   sel_rsp;
  logic                last_dbg;
  logic                pick_dbg;
  logic                any_valid;

  function automatic irq_pkg::target_e decode(input logic [31:0] addr);
    if (addr[31:24] == irq_pkg::clint_base[31:24]) begin
      return irq_pkg::tgt_clint;
    end
    if (addr[31:24] == irq_pkg::clic_base[31:24]) begin
      return irq_pkg::tgt_clic;
    end
    return irq_pkg::tgt_none;
  endfunction

  assign any_valid = core_req.valid | dbg_req.valid;

  // round robin. the port not served last goes first.
  assign pick_dbg = (core_req.valid && dbg_req.valid) ? ~last_dbg : dbg_req.valid;
  assign pick_req = pick_dbg ? dbg_req : core_req;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state    <= irq_pkg::arb_idle;
      last_dbg <= 1'b0;
    end else begin
      case (state)
        irq_pkg::arb_idle: begin
          if (any_valid) begin
            state    <= irq_pkg::arb_issue;
            last_dbg <= pick_dbg;
          end
        end
        irq_pkg::arb_issue: state <= irq_pkg::arb_wait;
        default: state <= irq_pkg::arb_idle;
      endcase
    end
  end

  // latched access, target sees only the offset.
  always_ff @(posedge clk) begin
    if (state == irq_pkg::arb_idle && any_valid) begin
      req_q      <= pick_req;
      req_q.addr <= {16'h0000, pick_req.addr[15:0]};
      tgt_q      <= decode(pick_req.addr);
    end
  end

  always_comb begin
    clint_req       = req_q;
    clint_req.valid = (state == irq_pkg::arb_issue) && (tgt_q == irq_pkg::tgt_clint);
    clic_req        = req_q;
    clic_req.valid  = (state == irq_pkg::arb_issue) && (tgt_q == irq_pkg::tgt_clic);
  end

  always_comb begin
    sel_rsp = '0;
    case (tgt_q)
      irq_pkg::tgt_clint: sel_rsp = clint_rsp;
      irq_pkg::tgt_clic:  sel_rsp = clic_rsp;
      // unmapped region answers itself with zero.
      default: sel_rsp.ready = 1'b1;
    endcase
    core_rsp = '0;
    dbg_rsp  = '0;
    if (state == irq_pkg::arb_wait) begin
      if (last_dbg) begin
        dbg_rsp = sel_rsp;
      end else begin
        core_rsp = sel_rsp;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst) !(clint_req.valid && clic_req.valid));
  assert property (@(posedge clk) disable iff (!rst) clint_req.valid |=> !clint_req.valid);
  assert property (@(posedge clk) disable iff (!rst) clic_req.valid |=> !clic_req.valid);
  assert property (@(posedge clk) disable iff (!rst) !(core_rsp.ready && dbg_rsp.ready));

endmodule

`default_nettype wire

//--- logic/clint.sv
`default_nettype none
`timescale 1ns/10ps

module clint (
  input  logic              clk,
  input  logic              rst,
  input  logic              rtc,
  input  irq_pkg::bus_req_t req,
  output irq_pkg::bus_rsp_t rsp,
  output logic              msip,
  output logic              mtip
);

  logic [1:0]  rtc_sync;
  logic        rtc_prev;
  logic        rtc_rise;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [15:0] off;
  logic        wr;
  logic        rd;
  logic [31:0] rdata_q;
  logic        ready_q;

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                        input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign off      = req.addr[15:0];
  assign wr       = req.valid && (req.wstrb != 4'b0000);
  assign rd       = req.valid && (req.wstrb == 4'b0000);
  assign rtc_rise = rtc_sync[1] & ~rtc_prev;

  always_ff @(posedge clk) begin
    if (!rst) begin
      rtc_sync <= 2'b00;
      rtc_prev <= 1'b0;
      mtime    <= '0;
      mtimecmp <= '1;
      msip     <= 1'b0;
      mtip     <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      rtc_sync <= {rtc_sync[0], rtc};
      rtc_prev <= rtc_sync[1];
      ready_q  <= req.valid;
      mtip     <= (mtime >= mtimecmp);
      if (wr && off == irq_pkg::clint_msip && req.wstrb[0]) begin
        msip <= req.wdata[0];
      end
      if (wr && off == irq_pkg::clint_mtimecmp_lo) begin
        mtimecmp[31:0] <= merge(mtimecmp[31:0], req.wdata, req.wstrb);
      end
      if (wr && off == irq_pkg::clint_mtimecmp_hi) begin
        mtimecmp[63:32] <= merge(mtimecmp[63:32], req.wdata, req.wstrb);
      end
      // a software write takes the tick.
      if (wr && off == irq_pkg::clint_mtime_lo) begin
        mtime[31:0] <= merge(mtime[31:0], req.wdata, req.wstrb);
      end else if (wr && off == irq_pkg::clint_mtime_hi) begin
        mtime[63:32] <= merge(mtime[63:32], req.wdata, req.wstrb);
      end else if (rtc_rise) begin
        mtime <= mtime + 64'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      case (off)
        irq_pkg::clint_msip:        rdata_q <= {31'b0, msip};
        irq_pkg::clint_mtimecmp_lo: rdata_q <= mtimecmp[31:0];
        irq_pkg::clint_mtimecmp_hi: rdata_q <= mtimecmp[63:32];
        irq_pkg::clint_mtime_lo:    rdata_q <= mtime[31:0];
        irq_pkg::clint_mtime_hi:    rdata_q <= mtime[63:32];
        default:                    rdata_q <= 32'h0;
      endcase
    end
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ready = ready_q;

  assert property (@(posedge clk) disable iff (!rst) req.valid |=> rsp.ready);
  assert property (@(posedge clk) disable iff (!rst) rsp.ready |-> $past(req.valid));

endmodule

`default_nettype wire

//--- logic/clic.sv
`default_nettype none
`timescale 1ns/10ps

module clic #(
  parameter int sources = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  irq_pkg::bus_req_t          req,
  output irq_pkg::bus_rsp_t          rsp,
  input  logic [sources-1:0]         irq_src,
  output logic                       meip,
  output logic [$clog2(sources)-1:0] irq_id
);

  localparam int id_w = $clog2(sources);

  logic [7:0]      cfg;
  logic [7:0]      ip   [sources];
  logic [7:0]      ie   [sources];
  logic [7:0]      attr [sources];
  logic [7:0]      ctl  [sources];
  logic [sources-1:0] src_q;

  logic [15:0]     off;
  logic [15:0]     rel;
  logic [id_w-1:0] idx;
  logic            in_int;
  logic            wr;
  logic            rd;
  logic [31:0]     rdata_q;
  logic            ready_q;

  logic            found;
  logic [7:0]      best_lvl;
  logic [id_w-1:0] best_idx;

  assign off    = req.addr[15:0];
  assign rel    = off - irq_pkg::clic_int_base;
  assign idx    = rel[id_w+1:2];
  assign in_int = (off >= irq_pkg::clic_int_base) && (rel < 16'(sources * 4));
  assign wr     = req.valid && (req.wstrb != 4'b0000);
  assign rd     = req.valid && (req.wstrb == 4'b0000);

  always_ff @(posedge clk) begin
    if (!rst) begin
      cfg     <= 8'h00;
      src_q   <= '0;
      ready_q <= 1'b0;
      for (int i = 0; i < sources; i++) begin
        ip[i]   <= 8'h00;
        ie[i]   <= 8'h00;
        attr[i] <= 8'h00;
        ctl[i]  <= 8'h00;
      end
    end else begin
      ready_q <= req.valid;
      src_q   <= irq_src;
      if (wr && off == irq_pkg::clic_cfg && req.wstrb[0]) begin
        cfg <= req.wdata[7:0];
      end
      if (wr && in_int) begin
        if (req.wstrb[0]) begin
          ip[idx] <= req.wdata[7:0];
        end
        if (req.wstrb[1]) begin
          ie[idx] <= req.wdata[15:8];
        end
        if (req.wstrb[2]) begin
          attr[idx] <= req.wdata[23:16];
        end
        if (req.wstrb[3]) begin
          ctl[idx] <= req.wdata[31:24];
        end
      end
      // line sampling wins over a same-cycle clear.
      for (int i = 0; i < sources; i++) begin
        if (attr[i][0]) begin
          if (irq_src[i] && !src_q[i]) begin
            ip[i][0] <= 1'b1;
          end
        end else begin
          ip[i][0] <= irq_src[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      if (off == irq_pkg::clic_cfg) begin
        rdata_q <= {24'h0, cfg};
      end else if (off == irq_pkg::clic_info) begin
        rdata_q <= 32'(sources);
      end else if (in_int) begin
        rdata_q <= {ctl[idx], attr[idx], ie[idx], ip[idx]};
      end else begin
        rdata_q <= 32'h0;
      end
    end
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ready = ready_q;

  // strict compare keeps the lowest index on a tie.
  always_comb begin
    found    = 1'b0;
    best_lvl = 8'h00;
    best_idx = '0;
    for (int i = 0; i < sources; i++) begin
      if (ip[i][0] && ie[i][0] && (!found || ctl[i] > best_lvl)) begin
        found    = 1'b1;
        best_lvl = ctl[i];
        best_idx = id_w'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      meip   <= 1'b0;
      irq_id <= '0;
    end else begin
      meip   <= found && (best_lvl > cfg);
      irq_id <= best_idx;
    end
  end

  assert property (@(posedge clk) disable iff (!rst)
    meip |-> $past(ie[best_idx][0] && ip[best_idx][0]));

endmodule

`default_nettype wire

//--- logic/irq_top.sv
`default_nettype none
`timescale 1ns/10ps

module irq_top #(
  parameter int sources = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rtc,
  input  irq_pkg::bus_req_t          core_req,
  input  irq_pkg::bus_req_t          dbg_req,
  output irq_pkg::bus_rsp_t          core_rsp,
  output irq_pkg::bus_rsp_t          dbg_rsp,
  input  logic [sources-1:0]         irq_src,
  output logic                       meip,
  output logic                       msip,
  output logic                       mtip,
  output logic [$clog2(sources)-1:0] irq_id
);

  irq_pkg::bus_req_t clint_req;
  irq_pkg::bus_req_t clic_req;
  irq_pkg::bus_rsp_t clint_rsp;
  irq_pkg::bus_rsp_t clic_rsp;

  bus_arbiter bus_arbiter_inst (
    .clk       (clk),
    .rst       (rst),
    .core_req  (core_req),
    .dbg_req   (dbg_req),
    .core_rsp  (core_rsp),
    .dbg_rsp   (dbg_rsp),
    .clint_req (clint_req),
    .clic_req  (clic_req),
    .clint_rsp (clint_rsp),
    .clic_rsp  (clic_rsp)
  );

  clint clint_inst (
    .clk  (clk),
    .rst  (rst),
    .rtc  (rtc),
    .req  (clint_req),
    .rsp  (clint_rsp),
    .msip (msip),
    .mtip (mtip)
  );

  clic #(
    .sources (sources)
  ) clic_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (clic_req),
    .rsp     (clic_rsp),
    .irq_src (irq_src),
    .meip    (meip),
    .irq_id  (irq_id)
  );

endmodule

`default_nettype wire

//--- tb/irq_tb.sv
`default_nettype none
`timescale 1ns/10ps

module irq_tb;

  localparam int sources = 16;
  localparam int id_w = $clog2(sources);
  localparam int wait_limit = 40;
  localparam int tick_limit = 20;
  localparam logic port_core = 1'b0;
  localparam logic port_dbg = 1'b1;

  logic              clk;
  logic              rst;
  logic              rtc;
  irq_pkg::bus_req_t core_req;
  irq_pkg::bus_req_t dbg_req;
  irq_pkg::bus_rsp_t core_rsp;
  irq_pkg::bus_rsp_t dbg_rsp;
  logic [sources-1:0] irq_src;
  logic              meip;
  logic              msip;
  logic              mtip;
  logic [id_w-1:0]   irq_id;

  irq_top #(
    .sources (sources)
  ) irq_top_inst (
    .clk      (clk),
    .rst      (rst),
    .rtc      (rtc),
    .core_req (core_req),
    .dbg_req  (dbg_req),
    .core_rsp (core_rsp),
    .dbg_rsp  (dbg_rsp),
    .irq_src  (irq_src),
    .meip     (meip),
    .msip     (msip),
    .mtip     (mtip),
    .irq_id   (irq_id)
  );

  always #4 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_id(input logic [id_w-1:0] got, input logic [id_w-1:0] exp,
                          input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  function automatic logic [31:0] src_addr(input int i);
    return irq_pkg::clic_base + 32'(irq_pkg::clic_int_base) + 32'(4 * i);
  endfunction

  // one access on one port with ready expected on the third cycle.
  task automatic run_access(input logic port, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    irq_pkg::bus_req_t r;
    logic done;
    int cycles;
    r.valid = 1'b1;
    r.addr = addr;
    r.wdata = wdata;
    r.wstrb = wstrb;
    done = 1'b0;
    cycles = 0;
    rdata = '0;
    @(posedge clk);
    if (port == port_dbg) begin
      dbg_req <= r;
    end else begin
      core_req <= r;
    end
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (cycles > wait_limit) begin
        fail_run("timeout: ready never came on the bus port");
      end else if ((port == port_dbg) ? dbg_rsp.ready : core_rsp.ready) begin
        done = 1'b1;
        rdata = (port == port_dbg) ? dbg_rsp.rdata : core_rsp.rdata;
      end
    end
    check_word(32'(cycles), 32'd3, "access latency");
    @(posedge clk);
    if (port == port_dbg) begin
      dbg_req.valid <= 1'b0;
    end else begin
      core_req.valid <= 1'b0;
    end
  endtask

  task automatic bus_write(input logic port, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] unused;
    run_access(port, addr, data, strb, unused);
  endtask

  task automatic bus_read(input logic port, input logic [31:0] addr, output logic [31:0] data);
    run_access(port, addr, 32'h0, 4'b0000, data);
  endtask

  task automatic wait_signal(input string name, input logic exp);
    int n;
    logic cur;
    n = 0;
    cur = ~exp;
    while (cur !== exp) begin
      @(negedge clk);
      n++;
      case (name)
        "meip": cur = meip;
        "mtip": cur = mtip;
        default: cur = msip;
      endcase
      if (cur !== exp && n > wait_limit) begin
        fail_run({"timeout: ", name, " never reached the expected level"});
      end
    end
  endtask

  task automatic wait_id(input logic [id_w-1:0] exp);
    int n;
    n = 0;
    @(negedge clk);
    while (irq_id !== exp) begin
      n++;
      if (n > wait_limit) begin
        fail_run("timeout: irq_id never changed to the expected source");
      end else begin
        @(negedge clk);
      end
    end
  endtask

  // one rising edge on rtc held long enough for the synchronizer.
  task automatic rtc_tick();
    @(posedge clk);
    rtc <= 1'b1;
    repeat (4) @(posedge clk);
    rtc <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task automatic after_reset();
    repeat (4) begin
      @(negedge clk);
      check_bit(core_rsp.ready, 1'b0, "core ready while idle");
      check_bit(dbg_rsp.ready, 1'b0, "debug ready while idle");
    end
    check_bit(meip, 1'b0, "meip after reset");
    check_bit(msip, 1'b0, "msip after reset");
    check_bit(mtip, 1'b0, "mtip after reset");
  endtask

  task automatic clic_regs();
    logic [31:0] shadow;
    logic [31:0] data;
    logic [31:0] got;
    shadow = '0;
    for (int b = 0; b < 4; b++) begin
      // ip and attr bit 0 kept clear so source 7 stays level and idle.
      data = $urandom() & 32'hfffe_fffe;
      bus_write(port_core, src_addr(7), data, 4'(1 << b));
      shadow[8*b +: 8] = data[8*b +: 8];
      bus_read(port_core, src_addr(7), got);
      check_word(got, shadow, "clic source word after byte write");
    end
    bus_write(port_core, irq_pkg::clic_base | 32'(irq_pkg::clic_cfg), 32'hffff_ff10, 4'b0001);
    bus_read(port_core, irq_pkg::clic_base | 32'(irq_pkg::clic_cfg), got);
    check_word(got, 32'h10, "clic cfg");
    bus_read(port_core, irq_pkg::clic_base | 32'(irq_pkg::clic_info), got);
    check_word(got, 32'(sources), "clic info");
  endtask

  task automatic level_and_edge();
    // source 3 level at ctl 8'h40 and source 5 edge at ctl 8'h30.
    bus_write(port_core, src_addr(3), 32'h4000_0100, 4'b1111);
    bus_write(port_core, src_addr(5), 32'h3001_0100, 4'b1111);
    @(posedge clk);
    irq_src[3] <= 1'b1;
    wait_signal("meip", 1'b1);
    check_id(irq_id, id_w'(3), "level source id");
    @(posedge clk);
    irq_src[3] <= 1'b0;
    wait_signal("meip", 1'b0);

    @(posedge clk);
    irq_src[5] <= 1'b1;
    @(posedge clk);
    irq_src[5] <= 1'b0;
    wait_signal("meip", 1'b1);
    check_id(irq_id, id_w'(5), "edge source id");
    repeat (6) @(negedge clk);
    check_bit(meip, 1'b1, "edge source still pending");
    bus_write(port_core, src_addr(5), 32'h0, 4'b0001);
    wait_signal("meip", 1'b0);

    @(posedge clk);
    irq_src[3] <= 1'b1;
    irq_src[5] <= 1'b1;
    @(posedge clk);
    irq_src[5] <= 1'b0;
    wait_id(id_w'(3));
    bus_write(port_core, src_addr(5), 32'h5000_0000, 4'b1000);
    wait_id(id_w'(5));
    // equal ctl goes to the lower index.
    bus_write(port_core, src_addr(5), 32'h4000_0000, 4'b1000);
    wait_id(id_w'(3));
    check_bit(meip, 1'b1, "meip with two pending sources");
    @(posedge clk);
    irq_src[3] <= 1'b0;
    bus_write(port_core, src_addr(5), 32'h0, 4'b0001);
    wait_signal("meip", 1'b0);
  endtask

  task automatic timer_irq();
    logic [31:0] t;
    logic [31:0] prev;
    logic        done;
    int          ticks;
    bus_write(port_core, irq_pkg::clint_base | 32'(irq_pkg::clint_msip), 32'h1, 4'b0001);
    wait_signal("msip", 1'b1);
    bus_write(port_core, irq_pkg::clint_base | 32'(irq_pkg::clint_msip), 32'h0, 4'b0001);
    wait_signal("msip", 1'b0);
    bus_write(port_core, irq_pkg::clint_base | 32'(irq_pkg::clint_mtimecmp_hi), 32'h0, 4'b1111);
    bus_write(port_core, irq_pkg::clint_base | 32'(irq_pkg::clint_mtimecmp_lo), 32'h5, 4'b1111);
    bus_read(port_core, irq_pkg::clint_base | 32'(irq_pkg::clint_mtime_lo), prev);
    check_word(prev, 32'h0, "mtime before any rtc edge");
    @(negedge clk);
    check_bit(mtip, 1'b0, "mtip below mtimecmp");
    ticks = 0;
    done = 1'b0;
    t = prev;
    while (!done) begin
      if (ticks >= tick_limit) begin
        fail_run("timeout: mtip never rose while rtc was toggled");
      end else begin
        rtc_tick();
        ticks++;
        bus_read(port_core, irq_pkg::clint_base | 32'(irq_pkg::clint_mtime_lo), t);
        check_bit(t >= prev, 1'b1, "mtime read went backwards");
        prev = t;
        @(negedge clk);
        done = mtip;
      end
    end
    check_word(32'(ticks), 32'd5, "rtc edges until mtip");
    check_word(t, 32'd5, "mtime low word");
    bus_read(port_core, irq_pkg::clint_base | 32'(irq_pkg::clint_mtime_hi), t);
    check_word(t, 32'h0, "mtime high word");
  endtask

  task automatic two_port_arbitration();
    irq_pkg::bus_req_t rc;
    irq_pkg::bus_req_t rd;
    logic [31:0] core_data;
    logic [31:0] dbg_data;
    logic core_done;
    logic dbg_done;
    int core_at;
    int dbg_at;
    int cyc;
    // a debug access first, so the core is next in turn.
    bus_read(port_dbg, irq_pkg::clic_base | 32'(irq_pkg::clic_info), core_data);
    check_word(core_data, 32'(sources), "clic info on debug port");
    rc = '0;
    rc.valid = 1'b1;
    rc.addr = irq_pkg::clic_base | 32'(irq_pkg::clic_cfg);
    rd = '0;
    rd.valid = 1'b1;
    rd.addr = irq_pkg::clint_base | 32'(irq_pkg::clint_mtimecmp_lo);
    core_done = 1'b0;
    dbg_done = 1'b0;
    core_at = 0;
    dbg_at = 0;
    cyc = 0;
    @(posedge clk);
    core_req <= rc;
    dbg_req <= rd;
    while (!(core_done && dbg_done)) begin
      @(negedge clk);
      cyc++;
      if (cyc > wait_limit) begin
        fail_run("timeout: ready never came on one of the two ports");
      end else begin
        if (core_rsp.ready) begin
          core_done = 1'b1;
          core_at = cyc;
          core_data = core_rsp.rdata;
        end
        if (dbg_rsp.ready) begin
          dbg_done = 1'b1;
          dbg_at = cyc;
          dbg_data = dbg_rsp.rdata;
        end
      end
      @(posedge clk);
      if (core_done) begin
        core_req.valid <= 1'b0;
      end
      if (dbg_done) begin
        dbg_req.valid <= 1'b0;
      end
    end
    check_word(core_data, 32'h10, "core read of clic cfg");
    check_word(dbg_data, 32'h5, "debug read of mtimecmp");
    check_word(32'(core_at), 32'd3, "core ready cycle");
    check_word(32'(dbg_at), 32'd6, "debug ready cycle");
  endtask

  task automatic unmapped_region();
    logic [31:0] got;
    bus_read(port_core, 32'h0400_0000, got);
    check_word(got, 32'h0, "unmapped read");
    bus_write(port_core, 32'h0400_0000, 32'hffff_ffff, 4'b1111);
    bus_write(port_dbg, 32'h0400_4000, 32'hffff_ffff, 4'b1111);
    bus_read(port_core, irq_pkg::clic_base | 32'(irq_pkg::clic_cfg), got);
    check_word(got, 32'h10, "clic cfg after unmapped write");
    bus_read(port_core, irq_pkg::clint_base | 32'(irq_pkg::clint_msip), got);
    check_word(got, 32'h0, "msip register after unmapped write");
    bus_read(port_core, irq_pkg::clint_base | 32'(irq_pkg::clint_mtimecmp_lo), got);
    check_word(got, 32'h5, "mtimecmp after unmapped write");
    check_bit(msip, 1'b0, "msip output after unmapped write");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    rtc = 1'b0;
    core_req = '0;
    dbg_req = '0;
    irq_src = '0;
    void'($urandom(32'h7c580ace));
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    after_reset();
    clic_regs();
    level_and_edge();
    timer_irq();
    two_port_arbitration();
    unmapped_region();
    repeat (2) @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
logic/irq_pkg.sv
logic/bus_arbiter.sv
logic/clint.sv
logic/clic.sv
logic/irq_top.sv
tb/irq_tb.sv

//--- Bender.yml
package:
  name: irq_block

sources:
  # package first, then the blocks, then the top level.
  - logic/irq_pkg.sv
  - logic/bus_arbiter.sv
  - logic/clint.sv
  - logic/clic.sv
  - logic/irq_top.sv

  - target: test
    files:
      - tb/irq_tb.sv
